//--- common/vec_consts.svh
/* Fixed sizes and encodings of the vector unit. VLEN is 512 with LMUL fixed at 1.
   Element width always follows SEW, so the load/store width field is not decoded. */
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// register geometry
`define VEC_VLEN  512
`define VEC_XLEN  32
`define VEC_WORDS 16
`define VEC_NREGS 32

// major opcodes
`define VEC_OP_LOAD  7'b0000111
`define VEC_OP_STORE 7'b0100111
`define VEC_OP_V     7'b1010111

// funct6 of the OPIVV forms that are kept
`define VEC_F6_ADD 6'b000000
`define VEC_F6_MAC 6'b111001

`endif

//--- common/vec_isa_pkg.sv
/* Instruction-side types. The vtype layout is the older one with SEW in bits 4:2
   and LMUL in bits 1:0; LMUL is carried but the unit always works as LMUL 1. */
`default_nettype none
`include "vec_consts.svh"

package vec_isa_pkg;

	// one whole vector register
	typedef logic [`VEC_VLEN-1:0] vreg_t;

	// vector register index
	typedef logic [4:0] vaddr_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_VSETVLI,
		OP_VSETVL,
		OP_LOAD,
		OP_STORE,
		OP_ADD,
		OP_MAC
	} vec_op_e;

	// codes above SEW32 are reserved here
	typedef enum logic [2:0] {
		SEW8  = 3'd0,
		SEW16 = 3'd1,
		SEW32 = 3'd2
	} sew_e;

	typedef struct packed {
		logic [5:0] rsvd;
		sew_e       sew;
		logic [1:0] lmul;
	} vtype_t;

	typedef struct packed {
		vec_op_e op;
		vaddr_t  vd;
		vaddr_t  vs1;
		vaddr_t  vs2;
		vtype_t  vtype;
	} vec_insn_t;

endpackage

`default_nettype wire

//--- common/vec_bus_pkg.sv
/* Bus-side types. Only whole 32-bit words move on the memory bus, so there is no
   byte strobe in the request; the top derives mem_wstrb from the write flag. */
`default_nettype none
`include "vec_consts.svh"

package vec_bus_pkg;

	// one word request, held with mem_valid until mem_ready
	typedef struct packed {
		logic [`VEC_XLEN-1:0] addr;
		logic [`VEC_XLEN-1:0] wdata;
		logic                 write;
	} mem_req_t;

	// response to the host core
	// waiting maps to pcpi_wait, the plain name is a reserved word
	typedef struct packed {
		logic                 wr;
		logic [`VEC_XLEN-1:0] rd;
		logic                 waiting;
		logic                 ready;
	} pcpi_rsp_t;

endpackage

`default_nettype wire

//--- verilog/vec_decoder.sv
/* Unit-stride loads/stores with nf, mew and mop zero are accepted; anything else
   decodes as OP_NONE. The host must hold pcpi_insn until pcpi_ready. */
`default_nettype none
`include "vec_consts.svh"

module vec_decoder (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pcpi_valid,
	input  logic [`VEC_XLEN-1:0]   pcpi_insn,
	input  logic                   ack,
	output vec_isa_pkg::vec_insn_t insn
);
	import vec_isa_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic       unit_mem;
	vec_op_e    op_next;

	assign opcode = pcpi_insn[6:0];
	assign funct3 = pcpi_insn[14:12];
	assign funct6 = pcpi_insn[31:26];

	// nf, mew and mop all zero, lumop/sumop zero, vector width codes only
	assign unit_mem = (pcpi_insn[31:26] == 6'b0) && (pcpi_insn[24:20] == 5'b0)
		&& (funct3 inside {3'b000, 3'b101, 3'b110, 3'b111});

	always_comb begin
		op_next = OP_NONE;
		case (opcode)
			`VEC_OP_LOAD: begin
				if (unit_mem) begin
					op_next = OP_LOAD;
				end
			end
			`VEC_OP_STORE: begin
				if (unit_mem) begin
					op_next = OP_STORE;
				end
			end
			`VEC_OP_V: begin
				if (funct3 == 3'b111) begin
					// bit 31 splits vsetvli from vsetvl
					if (!pcpi_insn[31]) begin
						op_next = OP_VSETVLI;
					end else if (pcpi_insn[30:25] == 6'b0) begin
						op_next = OP_VSETVL;
					end
				end else if (funct3 == 3'b000) begin
					if (funct6 == `VEC_F6_ADD) begin
						op_next = OP_ADD;
					end else if (funct6 == `VEC_F6_MAC) begin
						op_next = OP_MAC;
					end
				end
			end
			default: op_next = OP_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		// ack knocks out the held word for one cycle
		if (!rst_n || !pcpi_valid || ack) begin
			insn.op <= OP_NONE;
		end else begin
			insn.op <= op_next;
		end
		insn.vd    <= pcpi_insn[11:7];
		insn.vs1   <= pcpi_insn[19:15];
		insn.vs2   <= pcpi_insn[24:20];
		insn.vtype <= vtype_t'(pcpi_insn[30:20]);
	end

endmodule

`default_nettype wire

//--- vec_core/vec_sequencer.sv
/* vadd and the multiply-accumulate always cover all 16 words and ignore vl.
   Loads and stores move ceil(vl*SEW/32) words, clamped to 16; a load zeroes the rest. */
`default_nettype none
`include "vec_consts.svh"

module vec_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  vec_isa_pkg::vec_insn_t insn,
	input  logic [`VEC_XLEN-1:0]   rs1,
	input  logic [`VEC_XLEN-1:0]   rs2,
	output vec_bus_pkg::pcpi_rsp_t rsp,
	output vec_isa_pkg::vaddr_t    rf_waddr,
	output vec_isa_pkg::vaddr_t    rf_raddr1,
	output vec_isa_pkg::vaddr_t    rf_raddr2,
	output logic                   rf_we,
	output vec_isa_pkg::vreg_t     rf_wdata,
	input  vec_isa_pkg::vreg_t     rf_rdata1,
	input  vec_isa_pkg::vreg_t     rf_rdata2,
	input  vec_isa_pkg::vreg_t     rf_rdata3,
	output logic [`VEC_XLEN-1:0]   alu_a,
	output logic [`VEC_XLEN-1:0]   alu_b,
	output logic [`VEC_XLEN-1:0]   alu_acc,
	output logic                   alu_mac,
	output vec_isa_pkg::sew_e      alu_sew,
	input  logic [`VEC_XLEN-1:0]   alu_y,
	output logic                   mp_start,
	output logic                   mp_write,
	output logic [`VEC_XLEN-1:0]   mp_base,
	output logic [4:0]             mp_words,
	output vec_isa_pkg::vreg_t     mp_wdata,
	input  vec_isa_pkg::vreg_t     mp_rdata,
	input  logic                   mp_done
);
	import vec_isa_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_OPER, S_EXEC, S_MEM, S_WB} state_e;

	state_e               state;
	vec_op_e              op_q;
	vaddr_t               vd_q, vs1_q, vs2_q;
	sew_e                 sew_q;
	logic [6:0]           vl_q;
	logic [3:0]           idx;
	logic                 ready_q, wr_q, wait_q;
	logic [`VEC_XLEN-1:0] rd_q;
	vreg_t                opa, opb, acc, res;

	vtype_t     vt_src;
	sew_e       new_sew;
	logic [6:0] vlmax_new;
	logic [6:0] vl_new;
	logic [6:0] words_raw;
	logic       accept;

	function automatic logic [6:0] vlmax_of(sew_e s);
		case (s)
			SEW8:    return 7'(`VEC_VLEN / 8);
			SEW16:   return 7'(`VEC_VLEN / 16);
			default: return 7'(`VEC_VLEN / 32);
		endcase
	endfunction

	// vsetvl takes vtype from rs2, vsetvli from the immediate
	assign vt_src = (insn.op == OP_VSETVL) ? vtype_t'(rs2[10:0]) : insn.vtype;

	always_comb begin
		case (vt_src.sew)
			SEW8:    new_sew = SEW8;
			SEW16:   new_sew = SEW16;
			default: new_sew = SEW32;
		endcase
	end

	assign vlmax_new = vlmax_of(new_sew);

	// rs1 field of zero keeps the current vl
	always_comb begin
		vl_new = vl_q;
		if (insn.vs1 != '0) begin
			vl_new = (rs1 > vlmax_new) ? vlmax_new : rs1[6:0];
		end
	end

	// words touched by vl elements, rounded up
	always_comb begin
		case (sew_q)
			SEW8:    words_raw = (vl_q + 7'd3) >> 2;
			SEW16:   words_raw = (vl_q + 7'd1) >> 1;
			default: words_raw = vl_q;
		endcase
	end

	assign mp_words = (words_raw > 7'(`VEC_WORDS)) ? 5'(`VEC_WORDS) : words_raw[4:0];

	// ready_q guards the one cycle where the decoder still shows the old word
	assign accept = (state == S_IDLE) && (insn.op != OP_NONE) && !ready_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			op_q     <= OP_NONE;
			ready_q  <= 1'b0;
			wr_q     <= 1'b0;
			wait_q   <= 1'b0;
			mp_start <= 1'b0;
			vl_q     <= '0;
			sew_q    <= SEW8;
		end else begin
			ready_q  <= 1'b0;
			wr_q     <= 1'b0;
			mp_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (accept) begin
						op_q <= insn.op;
						case (insn.op)
							OP_VSETVLI, OP_VSETVL: begin
								vl_q    <= vl_new;
								sew_q   <= new_sew;
								ready_q <= 1'b1;
								wr_q    <= 1'b1;
							end
							OP_LOAD: begin
								mp_start <= 1'b1;
								wait_q   <= 1'b1;
								state    <= S_MEM;
							end
							default: begin
								wait_q <= 1'b1;
								state  <= S_OPER;
							end
						endcase
					end
				end
				S_OPER: begin
					if (op_q == OP_STORE) begin
						mp_start <= 1'b1;
						state    <= S_MEM;
					end else begin
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (idx == 4'(`VEC_WORDS - 1)) begin
						ready_q <= 1'b1;
						wait_q  <= 1'b0;
						state   <= S_WB;
					end
				end
				S_MEM: begin
					if (mp_done) begin
						ready_q <= 1'b1;
						wait_q  <= 1'b0;
						state   <= S_WB;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			vd_q  <= insn.vd;
			vs1_q <= insn.vs1;
			vs2_q <= insn.vs2;
			rd_q  <= {25'd0, vl_new};
		end
		if (state == S_OPER) begin
			opa <= rf_rdata1;
			opb <= rf_rdata2;
			acc <= rf_rdata3;
			idx <= '0;
		end
		if (state == S_EXEC) begin
			res[idx*`VEC_XLEN +: `VEC_XLEN] <= alu_y;
			idx <= idx + 4'd1;
		end
		if (state == S_MEM && mp_done && op_q == OP_LOAD) begin
			res <= mp_rdata;
		end
	end

	// store data comes out of port 1 from vd
	assign rf_raddr1 = (op_q == OP_STORE) ? vd_q : vs1_q;
	assign rf_raddr2 = vs2_q;
	assign rf_waddr  = vd_q;
	assign rf_we     = (state == S_WB) && (op_q != OP_STORE);
	assign rf_wdata  = res;

	assign alu_a   = opa[idx*`VEC_XLEN +: `VEC_XLEN];
	assign alu_b   = opb[idx*`VEC_XLEN +: `VEC_XLEN];
	assign alu_acc = acc[idx*`VEC_XLEN +: `VEC_XLEN];
	assign alu_mac = (op_q == OP_MAC);
	assign alu_sew = sew_q;

	assign mp_write = (op_q == OP_STORE);
	assign mp_base  = rs1;
	assign mp_wdata = opa;

	assign rsp = '{wr: wr_q, rd: rd_q, waiting: wait_q, ready: ready_q};

endmodule

`default_nettype wire

//--- vec_core/vec_regfile.sv
/* 32 x 512-bit vector registers, no reset, contents are undefined until written.
   Reads are combinational; a read of the address being written returns the old value. */
`default_nettype none
`include "vec_consts.svh"

module vec_regfile (
	input  logic                clk,
	input  logic                we,
	input  vec_isa_pkg::vaddr_t waddr,
	input  vec_isa_pkg::vaddr_t raddr1,
	input  vec_isa_pkg::vaddr_t raddr2,
	input  vec_isa_pkg::vaddr_t raddr3,
	input  vec_isa_pkg::vreg_t  wdata,
	output vec_isa_pkg::vreg_t  rdata1,
	output vec_isa_pkg::vreg_t  rdata2,
	output vec_isa_pkg::vreg_t  rdata3
);
	import vec_isa_pkg::*;

	vreg_t regs [`VEC_NREGS];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// two source operands
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// accumulator read of vd
	assign rdata3 = regs[raddr3];

endmodule

`default_nettype wire

//--- vec_core/vec_lane_alu.sv
/* Purely combinational, one 32-bit word per call. Every lane wraps modulo SEW
   and no carry crosses a lane boundary. */
`default_nettype none
`include "vec_consts.svh"

module vec_lane_alu (
	input  logic [`VEC_XLEN-1:0] a,
	input  logic [`VEC_XLEN-1:0] b,
	input  logic [`VEC_XLEN-1:0] acc,
	input  logic                 mac,
	input  vec_isa_pkg::sew_e    sew,
	output logic [`VEC_XLEN-1:0] y
);
	import vec_isa_pkg::*;

	// results for 8, 16 and 32 bit lanes
	logic [`VEC_XLEN-1:0] res [3];

	for (genvar w = 0; w < 3; w++) begin : g_width
		localparam int W = 8 << w;

		for (genvar l = 0; l < `VEC_XLEN / W; l++) begin : g_lane
			logic [W-1:0] la;
			logic [W-1:0] lb;
			logic [W-1:0] lc;

			assign la = a[l*W +: W];
			assign lb = b[l*W +: W];
			assign lc = acc[l*W +: W];

			// W-bit context truncates the product and sum
			assign res[w][l*W +: W] = mac ? lc + la * lb : la + lb;
		end
	end

	always_comb begin
		case (sew)
			SEW8:    y = res[0];
			SEW16:   y = res[1];
			default: y = res[2];
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/vec_mem_port.sv
/* One outstanding word request at a time, address steps by 4. A job of zero words
   gives done on the next cycle without bus traffic; wdata must stay stable for the job. */
`default_nettype none
`include "vec_consts.svh"

module vec_mem_port (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  write,
	input  logic [`VEC_XLEN-1:0]  base,
	input  logic [4:0]            words,
	input  vec_isa_pkg::vreg_t    wdata,
	output vec_isa_pkg::vreg_t    rdata,
	output logic                  done,
	output logic                  mem_valid,
	output vec_bus_pkg::mem_req_t mem_req,
	input  logic                  mem_ready,
	input  logic [`VEC_XLEN-1:0]  mem_rdata
);
	logic [4:0]           idx;
	logic [4:0]           words_q;
	logic                 write_q;
	logic [`VEC_XLEN-1:0] addr_q;

	assign mem_req = '{
		addr:  addr_q,
		wdata: wdata[idx[3:0]*`VEC_XLEN +: `VEC_XLEN],
		write: write_q
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				mem_valid <= (words != '0);
				done      <= (words == '0);
			end else if (mem_valid && mem_ready && (idx + 5'd1 == words_q)) begin
				// last word accepted
				mem_valid <= 1'b0;
				done      <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= base;
			words_q <= words;
			write_q <= write;
			idx     <= '0;
			rdata   <= '0;
		end else if (mem_valid && mem_ready) begin
			if (!write_q) begin
				rdata[idx[3:0]*`VEC_XLEN +: `VEC_XLEN] <= mem_rdata;
			end
			addr_q <= addr_q + 32'd4;
			idx    <= idx + 5'd1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pcpi_vec_top.sv
/* Vector coprocessor on the PCPI port. Memory accesses are whole aligned words,
   so mem_wstrb is all ones on writes and zero on reads. */
`default_nettype none
`include "vec_consts.svh"

module pcpi_vec_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 pcpi_valid,
	input  logic [`VEC_XLEN-1:0] pcpi_insn,
	input  logic [`VEC_XLEN-1:0] pcpi_rs1,
	input  logic [`VEC_XLEN-1:0] pcpi_rs2,
	output logic                 pcpi_wr,
	output logic [`VEC_XLEN-1:0] pcpi_rd,
	output logic                 pcpi_wait,
	output logic                 pcpi_ready,
	output logic                 mem_valid,
	output logic [`VEC_XLEN-1:0] mem_addr,
	output logic [`VEC_XLEN-1:0] mem_wdata,
	output logic [3:0]           mem_wstrb,
	input  logic                 mem_ready,
	input  logic [`VEC_XLEN-1:0] mem_rdata
);
	import vec_isa_pkg::*;
	import vec_bus_pkg::*;

	vec_insn_t            insn;
	pcpi_rsp_t            rsp;
	mem_req_t             mem_req;
	vaddr_t               rf_waddr, rf_raddr1, rf_raddr2;
	logic                 rf_we;
	vreg_t                rf_wdata, rf_rdata1, rf_rdata2, rf_rdata3;
	logic [`VEC_XLEN-1:0] alu_a, alu_b, alu_acc, alu_y;
	logic                 alu_mac;
	sew_e                 alu_sew;
	logic                 mp_start, mp_write, mp_done;
	logic [`VEC_XLEN-1:0] mp_base;
	logic [4:0]           mp_words;
	vreg_t                mp_wdata, mp_rdata;

	vec_decoder u_decoder (
		.clk(clk), .rst_n(rst_n), .pcpi_valid(pcpi_valid), .pcpi_insn(pcpi_insn),
		.ack(rsp.ready), .insn(insn)
	);

	vec_sequencer u_sequencer (
		.clk(clk), .rst_n(rst_n), .insn(insn), .rs1(pcpi_rs1), .rs2(pcpi_rs2), .rsp(rsp),
		.rf_waddr(rf_waddr), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
		.rf_we(rf_we), .rf_wdata(rf_wdata),
		.rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2), .rf_rdata3(rf_rdata3),
		.alu_a(alu_a), .alu_b(alu_b), .alu_acc(alu_acc), .alu_mac(alu_mac),
		.alu_sew(alu_sew), .alu_y(alu_y),
		.mp_start(mp_start), .mp_write(mp_write), .mp_base(mp_base), .mp_words(mp_words),
		.mp_wdata(mp_wdata), .mp_rdata(mp_rdata), .mp_done(mp_done)
	);

	// third port reads vd as the accumulator
	vec_regfile u_regfile (
		.clk(clk), .we(rf_we), .waddr(rf_waddr),
		.raddr1(rf_raddr1), .raddr2(rf_raddr2), .raddr3(rf_waddr), .wdata(rf_wdata),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2), .rdata3(rf_rdata3)
	);

	vec_lane_alu u_alu (
		.a(alu_a), .b(alu_b), .acc(alu_acc), .mac(alu_mac), .sew(alu_sew), .y(alu_y)
	);

	vec_mem_port u_mem_port (
		.clk(clk), .rst_n(rst_n), .start(mp_start), .write(mp_write), .base(mp_base),
		.words(mp_words), .wdata(mp_wdata), .rdata(mp_rdata), .done(mp_done),
		.mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	assign pcpi_wr    = rsp.wr;
	assign pcpi_rd    = rsp.rd;
	assign pcpi_wait  = rsp.waiting;
	assign pcpi_ready = rsp.ready;

	assign mem_addr  = mem_req.addr;
	assign mem_wdata = mem_req.wdata;
	assign mem_wstrb = {4{mem_req.write}};

endmodule

`default_nettype wire

//--- verification/pcpi_vec_tb.sv
/* Run from the project root so the test data path resolves. The memory model holds
   1 KiB of words and wraps above it; data lines carry eight words each. */
`default_nettype none
`include "vec_consts.svh"

module pcpi_vec_tb;

	localparam int TIMEOUT   = 200;
	localparam int MEM_WORDS = 256;

	logic                 clk;
	logic                 rst_n;
	logic                 pcpi_valid;
	logic [`VEC_XLEN-1:0] pcpi_insn;
	logic [`VEC_XLEN-1:0] pcpi_rs1;
	logic [`VEC_XLEN-1:0] pcpi_rs2;
	logic                 pcpi_wr;
	logic [`VEC_XLEN-1:0] pcpi_rd;
	logic                 pcpi_wait;
	logic                 pcpi_ready;
	logic                 mem_valid;
	logic [`VEC_XLEN-1:0] mem_addr;
	logic [`VEC_XLEN-1:0] mem_wdata;
	logic [3:0]           mem_wstrb;
	logic                 mem_ready = 1'b0;
	logic [`VEC_XLEN-1:0] mem_rdata = '0;

	logic [`VEC_XLEN-1:0] mem [MEM_WORDS];
	logic [1:0]           wait_left;
	int                   fd;
	int                   errors;
	int                   checks;
	logic                 aborted;

	pcpi_vec_top UUT (
		.clk(clk), .rst_n(rst_n), .pcpi_valid(pcpi_valid), .pcpi_insn(pcpi_insn),
		.pcpi_rs1(pcpi_rs1), .pcpi_rs2(pcpi_rs2), .pcpi_wr(pcpi_wr), .pcpi_rd(pcpi_rd),
		.pcpi_wait(pcpi_wait), .pcpi_ready(pcpi_ready), .mem_valid(mem_valid),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory model, 0 to 2 wait cycles before each mem_ready
	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			wait_left <= 2'd0;
		end else if (mem_valid && mem_ready) begin
			// whole words only, all strobes or none
			checks++;
			assert (mem_wstrb == 4'h0 || mem_wstrb == 4'hf) else begin
				errors++;
				$display("Error at %0t: mem_wstrb expected 0 or f got %h", $time, mem_wstrb);
			end
			if (mem_wstrb == 4'hf) begin
				mem[mem_addr[9:2]] = mem_wdata;
			end
			mem_ready <= 1'b0;
			wait_left <= 2'($urandom_range(2, 0));
		end else if (mem_valid) begin
			if (wait_left == 2'd0) begin
				mem_ready <= 1'b1;
				mem_rdata <= mem[mem_addr[9:2]];
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	task automatic issue_insn(input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] exp_rd);
		int   cycles;
		logic is_vset;
		logic wait_before;
		// only the vset forms write rd
		is_vset = (insn[6:0] == `VEC_OP_V) && (insn[14:12] == 3'b111);
		wait_before = 1'b0;
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		cycles = 0;
		@(negedge clk);
		while (!pcpi_ready && cycles < TIMEOUT) begin
			wait_before = pcpi_wait;
			@(negedge clk);
			cycles++;
		end
		if (!pcpi_ready) begin
			$display("timeout: no pcpi_ready within %0d cycles for insn %h", TIMEOUT, insn);
			errors++;
			aborted = 1'b1;
		end else begin
			checks += 2;
			assert (pcpi_wr == is_vset) else begin
				errors++;
				$display("Error at %0t: pcpi_wr expected %b got %b", $time, is_vset, pcpi_wr);
			end
			assert (!pcpi_wait) else begin
				errors++;
				$display("Error at %0t: pcpi_wait expected 0 got %b", $time, pcpi_wait);
			end
			if (is_vset) begin
				checks++;
				assert (pcpi_rd == exp_rd) else begin
					errors++;
					$display("Error at %0t: pcpi_rd expected %h got %h", $time, exp_rd, pcpi_rd);
				end
			end else begin
				// multi-cycle forms hold pcpi_wait up to the ready cycle
				checks++;
				assert (wait_before) else begin
					errors++;
					$display("Error at %0t: pcpi_wait before pcpi_ready expected 1 got %b",
						$time, wait_before);
				end
			end
		end
		@(posedge clk);
		pcpi_valid <= 1'b0;
		@(negedge clk);
		checks++;
		assert (!pcpi_ready) else begin
			errors++;
			$display("pcpi_ready stayed high for more than one cycle on insn %h", insn);
		end
	endtask

	task automatic expect_ignored(input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2);
		int   cycles;
		logic answered;
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		answered = 1'b0;
		for (cycles = 0; cycles < TIMEOUT && !answered; cycles++) begin
			@(negedge clk);
			answered = pcpi_ready || pcpi_wait;
		end
		checks++;
		assert (!answered) else begin
			errors++;
			$display("unsupported insn %h raised pcpi_ready or pcpi_wait", insn);
		end
		@(posedge clk);
		pcpi_valid <= 1'b0;
	endtask

	task automatic load_words;
		logic [31:0] addr;
		logic [31:0] word;
		int          rc;
		rc = $fscanf(fd, "%h", addr);
		for (int k = 0; k < 8; k++) begin
			rc = $fscanf(fd, "%h", word);
			mem[(addr >> 2) + k] = word;
		end
	endtask

	task automatic compare_words;
		logic [31:0] addr;
		logic [31:0] word;
		int          rc;
		rc = $fscanf(fd, "%h", addr);
		for (int k = 0; k < 8; k++) begin
			rc = $fscanf(fd, "%h", word);
			checks++;
			assert (mem[(addr >> 2) + k] == word) else begin
				errors++;
				$display("Error at %0t: mem[%h] expected %h got %h", $time, addr + 4 * k,
					word, mem[(addr >> 2) + k]);
			end
		end
	endtask

	initial begin
		int unsigned      seed;
		logic [7:0]       tag;
		logic [8*128-1:0] skipped;
		logic [31:0]      f0, f1, f2, f3;
		int               rc;

		seed = 32'h441f_5fda;
		void'($urandom(seed));
		errors     = 0;
		checks     = 0;
		aborted    = 1'b0;
		rst_n      = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn  = '0;
		pcpi_rs1   = '0;
		pcpi_rs2   = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'hc0de_0000 | (i << 2);
		end
		fd = $fopen("verification/pcpi_vec_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			errors++;
			aborted = 1'b1;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		while (!aborted && $fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": rc = $fgets(skipped, fd);
				"M": load_words();
				"E": compare_words();
				"I": begin
					rc = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
					issue_insn(f0, f1, f2, f3);
				end
				"U": begin
					rc = $fscanf(fd, "%h %h %h", f0, f1, f2);
					expect_ignored(f0, f1, f2);
				end
				default: begin
					$display("unexpected line tag %c in the test data", tag);
					errors++;
					aborted = 1'b1;
				end
			endcase
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/vec_isa_pkg.sv
common/vec_bus_pkg.sv
verilog/vec_decoder.sv
vec_core/vec_sequencer.sv
vec_core/vec_regfile.sv
vec_core/vec_lane_alu.sv
verilog/vec_mem_port.sv
verilog/pcpi_vec_top.sv
verification/pcpi_vec_tb.sv

//--- verification/pcpi_vec_testdata.txt
# M addr w0..w7: memory preload. I insn rs1 rs2 rd: rd is checked for vset forms only.
# U insn rs1 rs2: must get no response. E addr w0..w7: expected memory words.
M 00000000 7fff80f0 7fff80f1 7fff80f2 7fff80f3 7fff80f4 7fff80f5 7fff80f6 7fff80f7
M 00000020 7fff80f8 7fff80f9 7fff80fa 7fff80fb 7fff80fc 7fff80fd 7fff80fe 7fff80ff
M 00000040 00030010 01030010 02030010 03030010 04030010 05030010 06030010 07030010
M 00000060 08030010 09030010 0a030010 0b030010 0c030010 0d030010 0e030010 0f030010
I 0005f557 00000040 00000000 00000040
I 0045f557 000003e8 00000000 00000020
I 80c5f557 00000064 00000008 00000010
I 00807557 00000000 00000000 00000010
I 0205e087 00000000 00000000 00000000
I 0205e107 00000040 00000000 00000000
I 0205e0a7 00000100 00000000 00000000
I 022081d7 00000000 00000000 00000000
I 0205e1a7 00000140 00000000 00000000
I 0005f557 00000014 00000000 00000014
I 02208257 00000000 00000000 00000000
I 0205e287 00000000 00000000 00000000
I 0005f557 00000040 00000000 00000040
I 0205e227 00000180 00000000 00000000
I 0205e2a7 000001c0 00000000 00000000
I 0045f557 00000020 00000000 00000020
I 0205e307 00000040 00000000 00000000
I e6208357 00000000 00000000 00000000
I 0205e327 00000200 00000000 00000000
U 0ac5e087 00000000 00000004
E 00000100 7fff80f0 7fff80f1 7fff80f2 7fff80f3 7fff80f4 7fff80f5 7fff80f6 7fff80f7
E 00000120 7fff80f8 7fff80f9 7fff80fa 7fff80fb 7fff80fc 7fff80fd 7fff80fe 7fff80ff
E 00000140 80028100 81028101 82028102 83028103 84028104 85028105 86028106 87028107
E 00000160 88028108 89028109 8a02810a 8b02810b 8c02810c 8d02810d 8e02810e 8f02810f
E 00000180 7f028000 80028001 81028002 82028003 83028004 84028005 85028006 86028007
E 000001a0 87028008 88028009 8902800a 8a02800b 8b02800c 8c02800d 8d02800e 8e02800f
E 000001c0 7fff80f0 7fff80f1 7fff80f2 7fff80f3 7fff80f4 00000000 00000000 00000000
E 000001e0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
E 00000200 80000f10 80000f20 80000f30 80000f40 80000f50 80000f60 80000f70 80000f80
E 00000220 80000f90 80000fa0 80000fb0 80000fc0 80000fd0 80000fe0 80000ff0 80001000
